// File: hw/accel_mem_pkg.sv
`default_nettype none

package accel_mem_pkg;

    localparam int LANES  = 4;   // Lanes per scratchpad word
    localparam int LANE_W = 16;
    localparam int ELEM_W = 8;   // Operand bits used in each lane
    localparam int WORD_W = LANES * LANE_W;

    // One scratchpad word as lanes or as a single wide value
    typedef union packed {
        logic signed [LANES-1:0][LANE_W-1:0] lanes;
        logic signed [WORD_W-1:0]            scalar;
    } mem_word_u;

endpackage

`default_nettype wire

// File: hw/accel_reg_pkg.sv
`default_nettype none

package accel_reg_pkg;

    localparam logic [11:0] CTRL_OFS   = 12'h000;
    localparam logic [11:0] STATUS_OFS = 12'h004;
    localparam logic [11:0] MEM_BASE   = 12'h100;  // Lane window, one lane per 32-bit slot

    // CTRL fields
    localparam int START_BIT = 0;
    localparam int OP_BIT    = 1;  // 0 add, 1 dot
    localparam int SRC_A_LSB = 4;
    localparam int SRC_B_LSB = 8;
    localparam int DST_LSB   = 12;
    localparam int FIELD_W   = 4;

    // STATUS bits
    localparam int BUSY_BIT = 0;
    localparam int DONE_BIT = 1;

endpackage

`default_nettype wire

// File: hw/apb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module apb_ctrl import accel_mem_pkg::*, accel_reg_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [11:0]              paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     add_start,
    output logic                     dot_start,
    output logic [$clog2(DEPTH)-1:0] src_a,
    output logic [$clog2(DEPTH)-1:0] src_b,
    output logic [$clog2(DEPTH)-1:0] dst,
    input  logic                     add_done,
    input  logic                     dot_done,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [$clog2(DEPTH)-1:0] mem_addr,
    output mem_word_u                mem_wdata,
    output logic [LANES-1:0]         mem_wmask,
    input  logic                     mem_gnt,
    input  mem_word_u                mem_rdata
);

    localparam int AW  = $clog2(DEPTH);
    localparam int LW  = $clog2(LANES);
    localparam int WIN = DEPTH * LANES * 4;  // Window size in bytes
    localparam logic [1:0] M_IDLE = 2'd0, M_RD = 2'd1, M_DONE = 2'd2;

    logic              access, ctrl_sel, status_sel, mem_sel, ctrl_wr;
    logic [11:0]       mem_ofs;
    logic [LW-1:0]     mem_lane;
    logic [LANE_W-1:0] sel_lane;
    logic [1:0]        m_state;
    logic [31:0]       lane_q;
    logic              busy_q, done_q, op_q;

    assign access     = psel && penable;
    assign ctrl_sel   = paddr == CTRL_OFS;
    assign status_sel = paddr == STATUS_OFS;
    assign mem_sel    = (paddr >= MEM_BASE) && (int'(paddr) < int'(MEM_BASE) + WIN);
    assign mem_ofs    = paddr - MEM_BASE;
    assign mem_lane   = mem_ofs[2 +: LW];
    assign sel_lane   = mem_rdata.lanes[mem_lane];
    assign ctrl_wr    = access && ctrl_sel && pwrite;

    // Lane access becomes a one-lane word request
    assign mem_req   = access && mem_sel && (m_state == M_IDLE);
    assign mem_we    = pwrite;
    assign mem_addr  = mem_ofs[2+LW +: AW];
    assign mem_wdata = {LANES{pwdata[LANE_W-1:0]}};
    assign mem_wmask = LANES'(1) << mem_lane;

    assign pready  = access && (!mem_sel || m_state == M_DONE);
    assign pslverr = pready && (!(ctrl_sel || status_sel || mem_sel) || (ctrl_wr && busy_q));

    always_comb begin
        prdata = '0;
        if (status_sel) begin
            prdata[BUSY_BIT] = busy_q;
            prdata[DONE_BIT] = done_q;
        end else if (ctrl_sel) begin
            prdata[OP_BIT]               = op_q;
            prdata[SRC_A_LSB +: FIELD_W] = FIELD_W'(src_a);
            prdata[SRC_B_LSB +: FIELD_W] = FIELD_W'(src_b);
            prdata[DST_LSB +: FIELD_W]   = FIELD_W'(dst);
        end else if (mem_sel) begin
            prdata = lane_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_state   <= M_IDLE;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            op_q      <= 1'b0;
            add_start <= 1'b0;
            dot_start <= 1'b0;
            src_a     <= '0;
            src_b     <= '0;
            dst       <= '0;
        end else begin
            add_start <= 1'b0;
            dot_start <= 1'b0;
            case (m_state)
                M_IDLE:  if (mem_req && mem_gnt) m_state <= pwrite ? M_DONE : M_RD;
                M_RD:    m_state <= M_DONE;  // Lane captured from rdata
                default: m_state <= M_IDLE;
            endcase
            if (add_done || dot_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (ctrl_wr && !busy_q) begin
                op_q  <= pwdata[OP_BIT];
                src_a <= AW'(pwdata[SRC_A_LSB +: FIELD_W]);
                src_b <= AW'(pwdata[SRC_B_LSB +: FIELD_W]);
                dst   <= AW'(pwdata[DST_LSB +: FIELD_W]);
                if (pwdata[START_BIT]) begin
                    busy_q    <= 1'b1;
                    done_q    <= 1'b0;
                    add_start <= !pwdata[OP_BIT];
                    dot_start <= pwdata[OP_BIT];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_state == M_RD) begin
            lane_q <= {{(32-LANE_W){sel_lane[LANE_W-1]}}, sel_lane};
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import accel_mem_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [2:0]                    req,
    input  logic [2:0]                    we,
    input  logic [2:0][$clog2(DEPTH)-1:0] addr,
    input  mem_word_u [2:0]               wdata,
    input  logic [2:0][LANES-1:0]         wmask,
    output logic [2:0]                    gnt,
    output mem_word_u                     rdata,
    output logic                          sram_en,
    output logic                          sram_we,
    output logic [$clog2(DEPTH)-1:0]      sram_addr,
    output mem_word_u                     sram_wdata,
    output logic [LANES-1:0]              sram_wmask,
    input  mem_word_u                     sram_rdata
);

    logic [1:0] last_q;  // Last winner, lowest priority next
    logic [1:0] sel;
    logic       any;
    logic [2:0] rd_own;  // Owner of the read returning this cycle

    always_comb begin
        logic [1:0] idx;
        sel = last_q;
        any = 1'b0;
        for (int k = 1; k <= 3; k++) begin
            idx = 2'((int'(last_q) + k) % 3);
            if (!any && req[idx]) begin
                sel = idx;
                any = 1'b1;
            end
        end
    end

    assign gnt        = any ? (3'b001 << sel) : 3'b000;
    assign sram_en    = any;
    assign sram_we    = we[sel];
    assign sram_addr  = addr[sel];
    assign sram_wdata = wdata[sel];
    assign sram_wmask = wmask[sel];
    assign rdata      = (|rd_own) ? sram_rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= 2'd2;  // Requester 0 wins first
            rd_own <= '0;
        end else begin
            rd_own <= (any && !we[sel]) ? gnt : 3'b000;
            if (any) begin
                last_q <= sel;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vec_accel.sv
`timescale 1ns/1ps
`default_nettype none

module vec_accel import accel_mem_pkg::*; #(
    parameter int DEPTH     = 16,
    parameter int VEC_WORDS = 2,
    parameter int TILE      = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam int AW = $clog2(DEPTH);

    // Requester 0 is APB, 1 the add unit, 2 the dot unit
    logic [2:0]             req, we, gnt;
    logic [2:0][AW-1:0]     addr;
    mem_word_u [2:0]        wdata;
    logic [2:0][LANES-1:0]  wmask;
    mem_word_u              rdata;

    logic                   add_start, dot_start, add_done, dot_done;
    logic [AW-1:0]          src_a, src_b, dst;

    logic                   sram_en, sram_we;
    logic [AW-1:0]          sram_addr;
    mem_word_u              sram_wdata, sram_rdata;
    logic [LANES-1:0]       sram_wmask;

    apb_ctrl #(.DEPTH(DEPTH)) u_apb (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .add_start(add_start), .dot_start(dot_start),
        .src_a(src_a), .src_b(src_b), .dst(dst),
        .add_done(add_done), .dot_done(dot_done),
        .mem_req(req[0]), .mem_we(we[0]), .mem_addr(addr[0]),
        .mem_wdata(wdata[0]), .mem_wmask(wmask[0]),
        .mem_gnt(gnt[0]), .mem_rdata(rdata)
    );

    vec_add_unit #(.DEPTH(DEPTH), .VEC_WORDS(VEC_WORDS), .TILE(TILE)) u_add (
        .clk(clk), .rst(rst), .start(add_start),
        .src_a(src_a), .src_b(src_b), .dst(dst), .done(add_done),
        .mem_req(req[1]), .mem_we(we[1]), .mem_addr(addr[1]),
        .mem_wdata(wdata[1]), .mem_wmask(wmask[1]),
        .mem_gnt(gnt[1]), .mem_rdata(rdata)
    );

    vec_dot_unit #(.DEPTH(DEPTH), .VEC_WORDS(VEC_WORDS)) u_dot (
        .clk(clk), .rst(rst), .start(dot_start),
        .src_a(src_a), .src_b(src_b), .dst(dst), .done(dot_done),
        .mem_req(req[2]), .mem_we(we[2]), .mem_addr(addr[2]),
        .mem_wdata(wdata[2]), .mem_wmask(wmask[2]),
        .mem_gnt(gnt[2]), .mem_rdata(rdata)
    );

    mem_arbiter #(.DEPTH(DEPTH)) u_arb (
        .clk(clk), .rst(rst),
        .req(req), .we(we), .addr(addr), .wdata(wdata), .wmask(wmask),
        .gnt(gnt), .rdata(rdata),
        .sram_en(sram_en), .sram_we(sram_we), .sram_addr(sram_addr),
        .sram_wdata(sram_wdata), .sram_wmask(sram_wmask), .sram_rdata(sram_rdata)
    );

    vec_sram #(.DEPTH(DEPTH)) u_sram (
        .clk(clk), .en(sram_en), .we(sram_we), .addr(sram_addr),
        .wdata(sram_wdata), .wmask(sram_wmask), .rdata(sram_rdata)
    );

endmodule

`default_nettype wire

// File: hw/vec_add_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_add_unit import accel_mem_pkg::*; #(
    parameter int DEPTH     = 16,
    parameter int VEC_WORDS = 2,
    parameter int TILE      = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [$clog2(DEPTH)-1:0] src_a,
    input  logic [$clog2(DEPTH)-1:0] src_b,
    input  logic [$clog2(DEPTH)-1:0] dst,
    output logic                     done,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [$clog2(DEPTH)-1:0] mem_addr,
    output mem_word_u                mem_wdata,
    output logic [LANES-1:0]         mem_wmask,
    input  logic                     mem_gnt,
    input  mem_word_u                mem_rdata
);

    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(LANES);
    localparam int WW = (VEC_WORDS > 1) ? $clog2(VEC_WORDS) : 1;
    localparam logic [2:0] S_IDLE = 3'd0, S_FETCH_A = 3'd1, S_FETCH_B = 3'd2;
    localparam logic [2:0] S_SUM = 3'd3, S_WRITE = 3'd4;

    logic [2:0]             state;
    logic                   pend;  // Read granted, data this cycle
    logic [WW-1:0]          word;
    logic [LW-1:0]          lane;
    logic                   last_word;
    logic [AW-1:0]          a_base, b_base, d_base;
    mem_word_u              a_q, b_q, res_q;
    logic signed [ELEM_W:0] tile_sum [TILE];

    assign last_word = word == WW'(VEC_WORDS - 1);

    always_comb begin
        for (int t = 0; t < TILE; t++) begin
            tile_sum[t] = $signed(a_q.lanes[lane + LW'(t)][ELEM_W-1:0])
                        + $signed(b_q.lanes[lane + LW'(t)][ELEM_W-1:0]);
        end
    end

    assign mem_req   = (state == S_FETCH_A || state == S_FETCH_B) ? !pend : (state == S_WRITE);
    assign mem_we    = state == S_WRITE;
    assign mem_wdata = res_q;
    assign mem_wmask = '1;

    always_comb begin
        case (state)
            S_FETCH_A: mem_addr = a_base + AW'(word);
            S_FETCH_B: mem_addr = b_base + AW'(word);
            default:   mem_addr = d_base + AW'(word);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            pend  <= 1'b0;
            word  <= '0;
            lane  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    word  <= '0;
                    state <= S_FETCH_A;
                end
                S_FETCH_A, S_FETCH_B: begin
                    if (pend) begin
                        pend  <= 1'b0;
                        lane  <= '0;
                        state <= (state == S_FETCH_A) ? S_FETCH_B : S_SUM;
                    end else if (mem_gnt) begin
                        pend <= 1'b1;
                    end
                end
                S_SUM: begin
                    if (lane == LW'(LANES - TILE)) state <= S_WRITE;
                    else lane <= lane + LW'(TILE);
                end
                S_WRITE: if (mem_gnt) begin
                    if (last_word) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        word  <= word + 1'b1;
                        state <= S_FETCH_A;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            a_base <= src_a;
            b_base <= src_b;
            d_base <= dst;
        end
        if (pend && state == S_FETCH_A) a_q <= mem_rdata;
        if (pend && state == S_FETCH_B) b_q <= mem_rdata;
        if (state == S_SUM) begin
            for (int t = 0; t < TILE; t++) begin
                res_q.lanes[lane + LW'(t)] <=
                    {{(LANE_W-ELEM_W-1){tile_sum[t][ELEM_W]}}, tile_sum[t]};  // Sign extend
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vec_dot_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dot_unit import accel_mem_pkg::*; #(
    parameter int DEPTH     = 16,
    parameter int VEC_WORDS = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [$clog2(DEPTH)-1:0] src_a,
    input  logic [$clog2(DEPTH)-1:0] src_b,
    input  logic [$clog2(DEPTH)-1:0] dst,
    output logic                     done,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [$clog2(DEPTH)-1:0] mem_addr,
    output mem_word_u                mem_wdata,
    output logic [LANES-1:0]         mem_wmask,
    input  logic                     mem_gnt,
    input  mem_word_u                mem_rdata
);

    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(LANES);
    localparam int WW = (VEC_WORDS > 1) ? $clog2(VEC_WORDS) : 1;
    localparam logic [2:0] S_IDLE = 3'd0, S_FETCH_A = 3'd1, S_FETCH_B = 3'd2;
    localparam logic [2:0] S_MAC = 3'd3, S_WRITE = 3'd4;

    logic [2:0]                 state;
    logic                       pend;
    logic [WW-1:0]              word;
    logic [LW-1:0]              lane;
    logic                       last_word;
    logic [AW-1:0]              a_base, b_base, d_base;
    mem_word_u                  a_q, b_q;
    logic signed [2*ELEM_W-1:0] prod;
    logic signed [WORD_W-1:0]   acc;

    assign last_word = word == WW'(VEC_WORDS - 1);
    assign prod      = $signed(a_q.lanes[lane][ELEM_W-1:0]) * $signed(b_q.lanes[lane][ELEM_W-1:0]);

    assign mem_req   = (state == S_FETCH_A || state == S_FETCH_B) ? !pend : (state == S_WRITE);
    assign mem_we    = state == S_WRITE;
    assign mem_wmask = '1;  // Scalar fills the whole word

    always_comb begin
        mem_wdata.scalar = acc;
    end

    always_comb begin
        case (state)
            S_FETCH_A: mem_addr = a_base + AW'(word);
            S_FETCH_B: mem_addr = b_base + AW'(word);
            default:   mem_addr = d_base;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            pend  <= 1'b0;
            word  <= '0;
            lane  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    word  <= '0;
                    state <= S_FETCH_A;
                end
                S_FETCH_A, S_FETCH_B: begin
                    if (pend) begin
                        pend  <= 1'b0;
                        lane  <= '0;
                        state <= (state == S_FETCH_A) ? S_FETCH_B : S_MAC;
                    end else if (mem_gnt) begin
                        pend <= 1'b1;
                    end
                end
                S_MAC: begin
                    lane <= lane + 1'b1;
                    if (lane == LW'(LANES - 1)) begin
                        word  <= word + 1'b1;
                        state <= last_word ? S_WRITE : S_FETCH_A;
                    end
                end
                S_WRITE: if (mem_gnt) begin
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            a_base <= src_a;
            b_base <= src_b;
            d_base <= dst;
            acc    <= '0;
        end else if (state == S_MAC) begin
            acc <= acc + prod;  // One lane pair per cycle
        end
        if (pend && state == S_FETCH_A) a_q <= mem_rdata;
        if (pend && state == S_FETCH_B) b_q <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: hw/vec_sram.sv
`timescale 1ns/1ps
`default_nettype none

module vec_sram import accel_mem_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  mem_word_u                wdata,
    input  logic [LANES-1:0]         wmask,
    output mem_word_u                rdata
);

    mem_word_u mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int l = 0; l < LANES; l++) begin
                if (wmask[l]) begin
                    mem[addr].lanes[l] <= wdata.lanes[l];
                end
            end
        end else if (en) begin
            rdata <= mem[addr];  // Data valid the cycle after the grant
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the vec_accel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vec_accel -f vec_accel.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_vec_accel)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

// File: tests/tb_vec_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_accel import accel_mem_pkg::*, accel_reg_pkg::*; ();

    localparam int DEPTH     = 16;
    localparam int VEC_WORDS = 2;
    localparam int TILE      = 2;
    localparam int NROWS     = 6;
    localparam int NELEM     = LANES * VEC_WORDS;
    localparam int LIMIT     = 200 * NROWS + 500;  // Cycles

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int cycles = 0;
    int err_count;
    int tests_run;
    int tests_bad;

    // Stimulus table, one op per row
    bit          row_op    [NROWS];  // 0 add, 1 dot
    int          row_probe [NROWS];  // 0 none, 1 busy and status, 2 sharing
    int          row_src_a [NROWS];
    int          row_src_b [NROWS];
    int          row_dst   [NROWS];
    logic [15:0] row_a     [NROWS][NELEM];
    logic [15:0] row_b     [NROWS][NELEM];
    logic [31:0] row_exp   [NROWS][NELEM];

    vec_accel #(.DEPTH(DEPTH), .VEC_WORDS(VEC_WORDS), .TILE(TILE)) dut_i (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= LIMIT);
        $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] sext_lane(logic [31:0] v);
        return {{(32-LANE_W){v[LANE_W-1]}}, v[LANE_W-1:0]};
    endfunction

    function automatic logic [11:0] lane_addr(int word, int lane);
        return MEM_BASE + 12'(4 * (word * LANES + lane));
    endfunction

    // Signed element sum, one bit wider, sign-extended
    function automatic logic [31:0] add_model(logic [15:0] a, logic [15:0] b);
        int x;
        int y;
        x = $signed(a[ELEM_W-1:0]);
        y = $signed(b[ELEM_W-1:0]);
        return 32'(x + y);
    endfunction

    function automatic logic [31:0] dot_model(int r, int lane);
        longint    acc;
        int        x;
        int        y;
        mem_word_u w;
        acc = 0;
        for (int e = 0; e < NELEM; e++) begin
            x = $signed(row_a[r][e][ELEM_W-1:0]);
            y = $signed(row_b[r][e][ELEM_W-1:0]);
            acc += longint'(x * y);
        end
        w.scalar = acc;
        return sext_lane(32'(w.lanes[lane]));
    endfunction

    function automatic logic [31:0] ctrl_word(int r);
        logic [31:0] v;
        v = '0;
        v[OP_BIT] = row_op[r];
        v[SRC_A_LSB +: FIELD_W] = FIELD_W'(row_src_a[r]);
        v[SRC_B_LSB +: FIELD_W] = FIELD_W'(row_src_b[r]);
        v[DST_LSB +: FIELD_W]   = FIELD_W'(row_dst[r]);
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("Test %-16s ok", name);
        end else begin
            tests_bad++;
            $display("Test %-16s %0d mismatches", name, err_count - errs_before);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);  // Wait states for memory window
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] ignored;
        apb_transfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic lane_write(input int word, input int lane, input logic [31:0] data);
        logic err;
        apb_write(lane_addr(word, lane), data, err);
        check("pslverr", 32'(err), 32'h0);
    endtask

    task automatic lane_read(input int word, input int lane, output logic [31:0] data);
        logic err;
        apb_read(lane_addr(word, lane), data, err);
        check("pslverr", 32'(err), 32'h0);
    endtask

    task automatic wait_done(output logic [31:0] status);
        logic err;
        status = '0;
        while (!status[DONE_BIT]) begin
            apb_read(STATUS_OFS, status, err);
        end
    endtask

    task automatic fill_table();
        logic [15:0] edge_a [NELEM];
        logic [15:0] edge_b [NELEM];
        // Upper lane bits are noise the units must ignore
        edge_a    = '{16'h0080, 16'h007f, 16'hff00, 16'h0001,
                      16'h12ff, 16'h0040, 16'hffc0, 16'h0000};
        edge_b    = '{16'h0080, 16'h007f, 16'h0005, 16'hffff,
                      16'h00ff, 16'h0040, 16'h0080, 16'h0000};
        row_op    = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
        row_probe = '{0, 0, 0, 1, 2, 0};
        row_src_a = '{0, 0, 2, 0, 2, 4};
        row_src_b = '{2, 2, 0, 2, 4, 0};
        row_dst   = '{4, 4, 6, 4, 0, 6};
        for (int r = 0; r < NROWS; r++) begin
            for (int e = 0; e < NELEM; e++) begin
                case (r)
                    0: begin
                        row_a[r][e] = edge_a[e];
                        row_b[r][e] = edge_b[e];
                    end
                    1: begin
                        row_a[r][e] = 16'h0080;
                        row_b[r][e] = 16'h0080;
                    end
                    2: begin
                        row_a[r][e] = 16'hff80;  // Most negative dot result
                        row_b[r][e] = 16'h007f;
                    end
                    default: begin
                        row_a[r][e] = 16'($urandom);
                        row_b[r][e] = 16'($urandom);
                    end
                endcase
            end
            for (int k = 0; k < NELEM; k++) begin
                if (row_op[r]) row_exp[r][k] = (k < LANES) ? dot_model(r, k) : 32'h0;
                else row_exp[r][k] = add_model(row_a[r][k], row_b[r][k]);
            end
        end
    endtask

    task automatic reset_test();
        logic [31:0] rd;
        logic        err;
        int          errs;
        errs = err_count;
        apb_read(STATUS_OFS, rd, err);
        check("status", rd, 32'h0);
        apb_read(CTRL_OFS, rd, err);
        check("ctrl", rd, 32'h0);
        finish_test("reset", errs);
    endtask

    task automatic window_test();
        logic [31:0] vals [LANES];
        logic [31:0] rd;
        int          errs;
        errs = err_count;
        vals = '{32'h5555_1234, 32'h0000_8001, 32'habcd_7fff, 32'h0000_00ff};
        for (int l = 0; l < LANES; l++) lane_write(9, l, vals[l]);
        for (int l = 0; l < LANES; l++) begin
            lane_read(9, l, rd);
            check($sformatf("prdata word 9 lane %0d", l), rd, sext_lane(vals[l]));
        end
        vals[1] = 32'hffff_5a5a;
        lane_write(9, 1, vals[1]);
        for (int l = 0; l < LANES; l++) begin  // Neighbours unchanged
            lane_read(9, l, rd);
            check($sformatf("prdata word 9 lane %0d", l), rd, sext_lane(vals[l]));
        end
        finish_test("memory window", errs);
    endtask

    task automatic error_test();
        logic [31:0] rd;
        logic        err;
        int          errs;
        errs = err_count;
        apb_read(12'h008, rd, err);
        check("pslverr read 0x008", 32'(err), 32'h1);
        apb_write(12'h0fc, 32'h1, err);
        check("pslverr write 0x0fc", 32'(err), 32'h1);
        apb_read(MEM_BASE + 12'(DEPTH * LANES * 4), rd, err);
        check("pslverr past window", 32'(err), 32'h1);
        apb_read(STATUS_OFS, rd, err);
        check("status", rd, 32'h0);
        finish_test("unmapped", errs);
    endtask

    task automatic busy_probe(input int r);
        logic [31:0] rd;
        logic        err;
        apb_read(STATUS_OFS, rd, err);
        check("status", rd, 32'h1 << BUSY_BIT);  // Old done cleared
        apb_write(CTRL_OFS, 32'h0000_f0f3, err);
        check("pslverr ctrl busy", 32'(err), 32'h1);
        apb_read(CTRL_OFS, rd, err);
        check("ctrl", rd, ctrl_word(r));
    endtask

    task automatic share_probe();
        logic [31:0] vals [LANES];
        logic [31:0] rd;
        for (int l = 0; l < LANES; l++) begin
            vals[l] = $urandom;
            lane_write(12, l, vals[l]);
        end
        for (int l = 0; l < LANES; l++) begin
            lane_read(12, l, rd);
            check($sformatf("prdata word 12 lane %0d", l), rd, sext_lane(vals[l]));
        end
        lane_read(9, 1, rd);
        check("prdata word 9 lane 1", rd, 32'h0000_5a5a);
    endtask

    task automatic run_row(input int r);
        logic [31:0] rd;
        logic [31:0] st;
        logic        err;
        int          errs;
        int          nres;
        errs = err_count;
        nres = row_op[r] ? LANES : NELEM;
        for (int e = 0; e < NELEM; e++) begin
            lane_write(row_src_a[r] + e / LANES, e % LANES, {16'ha5c3, row_a[r][e]});
            lane_write(row_src_b[r] + e / LANES, e % LANES, {16'h3c5a, row_b[r][e]});
        end
        apb_write(CTRL_OFS, ctrl_word(r) | 32'h1, err);
        check("pslverr start", 32'(err), 32'h0);
        if (row_probe[r] == 1) busy_probe(r);
        if (row_probe[r] == 2) share_probe();
        wait_done(st);
        check("status", st, 32'h1 << DONE_BIT);
        for (int k = 0; k < nres; k++) begin
            lane_read(row_dst[r] + k / LANES, k % LANES, rd);
            check($sformatf("prdata row %0d lane %0d", r, k), rd, row_exp[r][k]);
        end
        finish_test($sformatf("row %0d %s", r, row_op[r] ? "dot" : "add"), errs);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        err_count = 0;
        tests_run = 0;
        tests_bad = 0;
        void'($urandom(32'h86b7d2aa));
        fill_table();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_test();
        window_test();
        error_test();
        for (int r = 0; r < NROWS; r++) run_row(r);
        $display("Tests run %0d, failing %0d, mismatches %0d", tests_run, tests_bad, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/vec_accel_chk.sv
`timescale 1ns/1ps
`default_nettype none

module vec_accel_chk import accel_mem_pkg::*; #(
    parameter int DEPTH = 16
) (
    input logic                          clk,
    input logic                          rst,
    input logic                          pready,
    input logic [2:0]                    req,
    input logic [2:0]                    we,
    input logic [2:0]                    gnt,
    input logic [2:0][$clog2(DEPTH)-1:0] addr,
    input mem_word_u [2:0]               wdata,
    input logic [2:0][LANES-1:0]         wmask
);

    a_one_gnt: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else $error("more than one grant in a cycle");

    a_gnt_req: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == 3'b000)
        else $error("grant to a requester without a request");

    // Window read still waits for rdata the cycle after its grant
    a_read_wait: assert property (@(posedge clk) disable iff (rst)
        gnt[0] && !we[0] |=> !pready)
        else $error("memory window read completed without waiting for read data");

    for (genvar i = 0; i < 3; i++) begin : g_hold
        a_hold: assert property (@(posedge clk) disable iff (rst)
            req[i] && !gnt[i] |=> req[i] && $stable(we[i]) && $stable(addr[i])
                && $stable(wdata[i]) && $stable(wmask[i]))
            else $error("requester %0d changed its request before the grant", i);
    end

endmodule

// Top level sees both the arbiter ports and the APB port
bind vec_accel vec_accel_chk #(.DEPTH(DEPTH)) chk_i (
    .clk(clk), .rst(rst), .pready(pready),
    .req(req), .we(we), .gnt(gnt), .addr(addr), .wdata(wdata), .wmask(wmask)
);

`default_nettype wire

// File: vec_accel.f
hw/accel_mem_pkg.sv
hw/accel_reg_pkg.sv
hw/vec_sram.sv
hw/mem_arbiter.sv
hw/apb_ctrl.sv
hw/vec_add_unit.sv
hw/vec_dot_unit.sv
hw/vec_accel.sv
tests/vec_accel_chk.sv
tests/tb_vec_accel.sv
